//--- filelist.f
design/exe_pkg.sv
design/alu_unit.sv
design/wb_buffer.sv
design/reg_writeback.sv
design/alu_wb_top.sv
+incdir+bench
bench/tb_alu_wb.sv

//--- Makefile
# Verilator flow for the ALU writeback slice

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_alu_wb
RTL_TOP   ?= alu_wb_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_STR  ?= STATUS: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) bench/tb_tasks.svh $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_tasks.svh
function automatic logic [31:0] next_rand();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

function automatic logic is_illegal(input alu_op_e op);
	return 4'(op) > 4'd9;                                   // only codes 0 to 9 are defined
endfunction

// the reference model works from the opcode rules and not from the DUT
function automatic logic [DATA_W-1:0] ref_result(input alu_op_e op,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
	logic [4:0] sh;
	logic       lt;
	sh = b[4:0];
	lt = (a[DATA_W-1] != b[DATA_W-1]) ? a[DATA_W-1] : (a < b);
	case (4'(op))
		4'd0: return a + b;
		4'd1: return a + ~b + 32'd1;
		4'd2: return a & b;
		4'd3: return a | b;
		4'd4: return a ^ b;
		4'd5: return a << sh;
		4'd6: return a >> sh;
		4'd7: return (a >> sh) | ~({DATA_W{1'b1}} >> sh) & {DATA_W{a[DATA_W-1]}};
		4'd8: return {31'd0, lt};
		4'd9: return {31'd0, a < b};
		default: return '0;
	endcase
endfunction

task automatic check_data(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
	if (got !== exp) begin
		$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		err_cnt++;
	end
endtask

task automatic check_rd(input string name, input logic [REG_AW-1:0] got,
		input logic [REG_AW-1:0] exp);
	if (got !== exp) begin
		$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		err_cnt++;
	end
endtask

task automatic check_exc(input string name, input exc_code_e got, input exc_code_e exp);
	if (got !== exp) begin
		$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		err_cnt++;
	end
endtask

task automatic finish_test(input string name, input int start_err);
	tests_run++;
	if (err_cnt != start_err)
		tests_failed++;
	$display("test %0d %s: %s", tests_run, name, (err_cnt == start_err) ? "ok" : "failed");
endtask

// holds the issue until the DUT takes it and returns one unit after the accepting edge
task automatic issue_op_task(input alu_op_e op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input logic [REG_AW-1:0] rd);
	logic rdy;
	issue_valid = 1'b1;
	issue_op = op;
	issue_a = a;
	issue_b = b;
	issue_rd = rd;
	rdy = issue_ready;
	while (!rdy) begin
		@(posedge clk);
		#1 rdy = issue_ready;
	end
	@(posedge clk);
	#1 issue_valid = 1'b0;
endtask

task automatic ext_write_task(input logic [REG_AW-1:0] rd, input logic [DATA_W-1:0] data);
	ext_valid = 1'b1;
	ext_rd = rd;
	ext_data = data;
	@(posedge clk);
	#1 ext_valid = 1'b0;
endtask

task automatic wait_idle();
	int n;
	n = 0;
	while ((alu_rd_q.size() != 0 || ext_rd_q.size() != 0) && n < 50) begin
		@(posedge clk);
		n++;
	end
	repeat (4) @(posedge clk);                              // room for a stray commit to show
	#1;
	if (alu_rd_q.size() != 0 || ext_rd_q.size() != 0) begin
		$display("results still outstanding after 50 cycles");
		err_cnt++;
	end
endtask

task automatic read_check(input logic [REG_AW-1:0] rd, input logic [DATA_W-1:0] exp);
	reg_raddr = rd;
	@(posedge clk);
	#1 check_data("reg_rdata", reg_rdata, exp);
endtask

task automatic issue_and_commit(input alu_op_e op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input logic [REG_AW-1:0] rd,
		input logic [DATA_W-1:0] exp_rb);
	int lat;
	issue_op_task(op, a, b, rd);
	lat = 1;                                                // the accepting edge
	while (!(commit_valid || exc_valid) && lat < 10) begin
		@(posedge clk);
		#1 lat++;
	end
	if (lat != 3) begin
		$display("issue to commit took %0d cycles instead of 3", lat);
		err_cnt++;
	end
	read_check(rd, exp_rb);
	wait_idle();
endtask

task automatic test_opcodes();
	int e;
	e = err_cnt;
	issue_and_commit(OP_ADD, 32'hFFFF_FFFF, 32'd1, 5'd1, 32'd0);
	issue_and_commit(OP_ADD, 32'h7FFF_FFFF, 32'd1, 5'd2, 32'h8000_0000);
	issue_and_commit(OP_SUB, 32'd0, 32'd1, 5'd3, ref_result(OP_SUB, 32'd0, 32'd1));
	issue_and_commit(OP_AND, 32'hF0F0_1234, 32'hFF00_FF00, 5'd4, 32'hF000_1200);
	issue_and_commit(OP_OR, 32'hF0F0_0000, 32'h0000_0F0F, 5'd5, 32'hF0F0_0F0F);
	issue_and_commit(OP_XOR, 32'hAAAA_5555, 32'hFFFF_FFFF, 5'd6, 32'h5555_AAAA);
	issue_and_commit(OP_SLL, 32'h8000_0001, 32'd0, 5'd7, 32'h8000_0001);
	issue_and_commit(OP_SLL, 32'h0000_0003, 32'hFFFF_FFFF, 5'd8, 32'h8000_0000);
	issue_and_commit(OP_SRL, 32'h8000_0000, 32'd31, 5'd9, 32'd1);
	issue_and_commit(OP_SRA, 32'h8000_0000, 32'd31, 5'd10, 32'hFFFF_FFFF);
	issue_and_commit(OP_SRA, 32'h8000_0000, 32'd0, 5'd11, 32'h8000_0000);
	issue_and_commit(OP_SLT, 32'hFFFF_FFFF, 32'd1, 5'd12, 32'd1);
	issue_and_commit(OP_SLT, 32'd1, 32'hFFFF_FFFF, 5'd13, 32'd0);
	issue_and_commit(OP_SLTU, 32'hFFFF_FFFF, 32'd1, 5'd14, 32'd0);
	issue_and_commit(OP_SLTU, 32'd1, 32'hFFFF_FFFF, 5'd15, 32'd1);
	finish_test("defined opcodes", e);
endtask

task automatic test_illegal();
	int e;
	e = err_cnt;
	ext_write_task(5'd20, 32'h1234_5678);                  // known value that must survive
	wait_idle();
	for (int code = 10; code < 16; code++)
		issue_and_commit(alu_op_e'(4'(code)), 32'hDEAD_BEEF, 32'd5, 5'd20, 32'h1234_5678);
	finish_test("illegal opcodes", e);
endtask

task automatic test_x0();
	int e;
	e = err_cnt;
	issue_and_commit(OP_OR, 32'hCAFE_F00D, 32'd0, 5'd0, 32'd0);
	finish_test("register 0", e);
endtask

// keeps the write port busy while issuing and returns the number of accepted issues
task automatic fill_buffer(input int cycles, input logic [REG_AW-1:0] rd_base,
		output int accepted);
	logic rdy;
	accepted = 0;
	for (int c = 0; c < cycles; c++) begin
		ext_valid = 1'b1;
		ext_rd = 5'(24 + c % 4);
		ext_data = 32'hE000_0000 + 32'(c);
		issue_valid = 1'b1;
		issue_op = OP_ADD;
		issue_a = 32'h100 * 32'(accepted + 1);
		issue_b = 32'h0000_0011;
		issue_rd = rd_base + 5'(accepted);
		rdy = issue_ready;
		@(posedge clk);
		if (rdy)
			accepted++;
		#1;
	end
	issue_valid = 1'b0;
endtask

task automatic test_backpressure();
	int e;
	int accepted;
	e = err_cnt;
	fill_buffer(8, 5'd16, accepted);
	if (accepted != WB_CREDITS || issue_ready) begin
		$display("%0d issues accepted under back-pressure, expected %0d", accepted, WB_CREDITS);
		err_cnt++;
	end
	if (alu_rd_q.size() != WB_CREDITS) begin
		$display("an ALU result retired while the external writer held the port");
		err_cnt++;
	end
	ext_valid = 1'b0;
	wait_idle();
	finish_test("back-pressure", e);
endtask

task automatic test_flush();
	int e;
	int accepted;
	e = err_cnt;
	fill_buffer(5, 5'd22, accepted);
	if (accepted != WB_CREDITS) begin
		$display("buffer not full before the flush, %0d issues accepted", accepted);
		err_cnt++;
	end
	flush = 1'b1;
	@(posedge clk);
	#1 flush = 1'b0;
	ext_valid = 1'b0;
	if (!issue_ready) begin
		$display("issue_ready low in the cycle after a flush");
		err_cnt++;
	end
	issue_and_commit(OP_XOR, 32'h0F0F_0F0F, 32'h00FF_00FF, 5'd21, 32'h0FF0_0FF0);
	read_check(5'd22, shadow[22]);
	read_check(5'd23, shadow[23]);
	finish_test("flush", e);
endtask

task automatic test_random();
	int e;
	int sent;
	logic rdy;
	logic [31:0] r;
	e = err_cnt;
	sent = 0;
	while (sent < 200) begin
		r = next_rand();
		if (!issue_valid && r[1:0] != 2'd0) begin
			issue_valid = 1'b1;
			issue_op = alu_op_e'(r[7:4]);
			issue_rd = r[12:8];
			issue_a = next_rand();
			issue_b = next_rand();
		end
		ext_valid = (r[17:16] == 2'd0);
		ext_rd = r[24:20];
		ext_data = next_rand();
		rdy = issue_ready;
		@(posedge clk);
		#1;
		if (issue_valid && rdy) begin
			sent++;
			issue_valid = 1'b0;
		end
	end
	ext_valid = 1'b0;
	wait_idle();
	for (int i = 0; i < 2**REG_AW; i++)
		read_check(5'(i), shadow[i]);
	finish_test("random stream", e);
endtask

//--- bench/tb_alu_wb.sv
`default_nettype none

module tb_alu_wb import exe_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int LCG_SEED = 68;
	localparam int NUM_TESTS = 6;
	localparam int TIMEOUT = NUM_TESTS * 200 * CLK_PERIOD;   // 200 cycles per test

	logic                clk;
	logic                reset_;
	logic                flush;
	logic                issue_valid;
	alu_op_e             issue_op;
	logic [DATA_W-1:0]   issue_a;
	logic [DATA_W-1:0]   issue_b;
	logic [REG_AW-1:0]   issue_rd;
	logic                issue_ready;
	logic                ext_valid;
	logic [REG_AW-1:0]   ext_rd;
	logic [DATA_W-1:0]   ext_data;
	logic                commit_valid;
	logic [REG_AW-1:0]   commit_rd;
	logic [DATA_W-1:0]   commit_data;
	logic                exc_valid;
	exc_code_e           exc_code;
	logic [REG_AW-1:0]   reg_raddr;
	logic [DATA_W-1:0]   reg_rdata;

	int                  err_cnt;
	int                  tests_run;
	int                  tests_failed;
	logic [31:0]         lcg_state;

	logic [REG_AW-1:0]   alu_rd_q [$];                       // expected ALU results in issue order
	logic [DATA_W-1:0]   alu_data_q [$];
	exc_code_e           alu_exc_q [$];
	logic [REG_AW-1:0]   ext_rd_q [$];                       // expected external writes
	logic [DATA_W-1:0]   ext_data_q [$];
	logic [DATA_W-1:0]   shadow [2**REG_AW];
	logic                ready_mid;
	logic                ext_at_edge;

	alu_wb_top dut_i (.*);

	`include "tb_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// issue_ready only moves on a rising edge, so the mid-cycle copy is what the edge sees
	always @(negedge clk) ready_mid <= issue_ready;

	always @(posedge clk) begin
		ext_at_edge <= ext_valid;                           // marks which source owned the port
		if (reset_) begin
			if (flush) begin
				alu_rd_q.delete();                          // everything in flight is dropped
				alu_data_q.delete();
				alu_exc_q.delete();
			end else if (issue_valid && ready_mid) begin
				alu_rd_q.push_back(issue_rd);
				alu_data_q.push_back(ref_result(issue_op, issue_a, issue_b));
				alu_exc_q.push_back(is_illegal(issue_op) ? EXC_ILLEGAL_OP : EXC_NONE);
			end
			if (ext_valid) begin
				ext_rd_q.push_back(ext_rd);
				ext_data_q.push_back(ext_data);
			end
		end
	end

	always @(negedge clk) begin
		logic [REG_AW-1:0] exp_rd;
		logic [DATA_W-1:0] exp_data;
		exc_code_e         exp_exc;
		logic              have_exp;
		if (reset_ && commit_valid) begin
			have_exp = 1'b1;
			if (ext_at_edge && ext_rd_q.size() != 0) begin
				exp_rd = ext_rd_q.pop_front();
				exp_data = ext_data_q.pop_front();
				exp_exc = EXC_NONE;
			end else if (!ext_at_edge && alu_rd_q.size() != 0) begin
				exp_rd = alu_rd_q.pop_front();
				exp_data = alu_data_q.pop_front();
				exp_exc = alu_exc_q.pop_front();
			end else begin
				$display("commit to register %0d arrived with nothing expected", commit_rd);
				err_cnt++;
				have_exp = 1'b0;
			end
			if (have_exp) begin
				check_exc("commit kind", EXC_NONE, exp_exc);
				check_rd("commit_rd", commit_rd, exp_rd);
				check_data("commit_data", commit_data, exp_data);
				if (exp_rd != '0)
					shadow[exp_rd] = exp_data;
			end
		end
		if (reset_ && exc_valid) begin
			if (alu_rd_q.size() == 0) begin
				$display("exception reported with no ALU result outstanding");
				err_cnt++;
			end else begin
				void'(alu_rd_q.pop_front());
				void'(alu_data_q.pop_front());
				check_exc("exc_code", exc_code, alu_exc_q.pop_front());
			end
		end
	end

	initial begin
		#(TIMEOUT);
		$display("watchdog expired, the test sequence did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		err_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		lcg_state = 32'(LCG_SEED);
		reset_ = 1'b0;
		flush = 1'b0;
		issue_valid = 1'b0;
		issue_op = OP_ADD;
		issue_a = '0;
		issue_b = '0;
		issue_rd = '0;
		ext_valid = 1'b0;
		ext_rd = '0;
		ext_data = '0;
		reg_raddr = '0;
		for (int i = 0; i < 2**REG_AW; i++)
			shadow[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset_ = 1'b1;
		if (!issue_ready || commit_valid || exc_valid) begin
			$display("outputs not at their reset values");
			err_cnt++;
		end
		test_opcodes();
		test_illegal();
		test_x0();
		test_backpressure();
		test_flush();
		test_random();
		$display("tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/alu_wb_top.sv
`default_nettype none

module alu_wb_top import exe_pkg::*; (
	input  logic                clk,
	input  logic                reset_,
	input  logic                flush,

	input  logic                issue_valid,
	input  alu_op_e             issue_op,
	input  logic [DATA_W-1:0]   issue_a,
	input  logic [DATA_W-1:0]   issue_b,
	input  logic [REG_AW-1:0]   issue_rd,
	output logic                issue_ready,

	input  logic                ext_valid,
	input  logic [REG_AW-1:0]   ext_rd,
	input  logic [DATA_W-1:0]   ext_data,

	output logic                commit_valid,
	output logic [REG_AW-1:0]   commit_rd,
	output logic [DATA_W-1:0]   commit_data,
	output logic                exc_valid,
	output exc_code_e           exc_code,

	input  logic [REG_AW-1:0]   reg_raddr,
	output logic [DATA_W-1:0]   reg_rdata
);

	logic                res_valid;                          // credit channel
	logic [REG_AW-1:0]   res_rd;
	logic [DATA_W-1:0]   res_data;
	exc_code_e           res_exc;
	logic                credit_return;

	logic                wb_valid;                           // drain channel
	logic [REG_AW-1:0]   wb_rd;
	logic [DATA_W-1:0]   wb_data;
	exc_code_e           wb_exc;
	logic                wb_ack;

	alu_unit u_alu (
		.clk           (clk),
		.reset_        (reset_),
		.flush         (flush),
		.issue_valid   (issue_valid),
		.issue_op      (issue_op),
		.issue_a       (issue_a),
		.issue_b       (issue_b),
		.issue_rd      (issue_rd),
		.issue_ready   (issue_ready),
		.credit_return (credit_return),
		.res_valid     (res_valid),
		.res_rd        (res_rd),
		.res_data      (res_data),
		.res_exc       (res_exc)
	);

	wb_buffer u_buf (
		.clk           (clk),
		.reset_        (reset_),
		.flush         (flush),
		.res_valid     (res_valid),
		.res_rd        (res_rd),
		.res_data      (res_data),
		.res_exc       (res_exc),
		.credit_return (credit_return),
		.wb_valid      (wb_valid),
		.wb_rd         (wb_rd),
		.wb_data       (wb_data),
		.wb_exc        (wb_exc),
		.wb_ack        (wb_ack)
	);

	reg_writeback u_wb (
		.clk           (clk),
		.reset_        (reset_),
		.wb_valid      (wb_valid),
		.wb_rd         (wb_rd),
		.wb_data       (wb_data),
		.wb_exc        (wb_exc),
		.wb_ack        (wb_ack),
		.ext_valid     (ext_valid),
		.ext_rd        (ext_rd),
		.ext_data      (ext_data),
		.commit_valid  (commit_valid),
		.commit_rd     (commit_rd),
		.commit_data   (commit_data),
		.exc_valid     (exc_valid),
		.exc_code      (exc_code),
		.reg_raddr     (reg_raddr),
		.reg_rdata     (reg_rdata)
	);

endmodule

`default_nettype wire

//--- design/reg_writeback.sv
`default_nettype none

module reg_writeback import exe_pkg::*; (
	input  logic                clk,
	input  logic                reset_,

	input  logic                wb_valid,
	input  logic [REG_AW-1:0]   wb_rd,
	input  logic [DATA_W-1:0]   wb_data,
	input  exc_code_e           wb_exc,
	output logic                wb_ack,

	input  logic                ext_valid,
	input  logic [REG_AW-1:0]   ext_rd,
	input  logic [DATA_W-1:0]   ext_data,

	output logic                commit_valid,
	output logic [REG_AW-1:0]   commit_rd,
	output logic [DATA_W-1:0]   commit_data,
	output logic                exc_valid,
	output exc_code_e           exc_code,

	input  logic [REG_AW-1:0]   reg_raddr,
	output logic [DATA_W-1:0]   reg_rdata
);

	logic [DATA_W-1:0]  rf [2**REG_AW];

	logic               buf_wr;
	logic               buf_exc;
	logic               wr_en;
	logic [REG_AW-1:0]  wr_rd;
	logic [DATA_W-1:0]  wr_data;

	// the external writer owns the port whenever it asks for it
	assign wb_ack  = wb_valid && !ext_valid;
	assign buf_wr  = wb_ack && (wb_exc == EXC_NONE);
	assign buf_exc = wb_ack && (wb_exc != EXC_NONE);          // an exception writes nothing

	assign wr_en   = ext_valid || buf_wr;
	assign wr_rd   = ext_valid ? ext_rd : wb_rd;
	assign wr_data = ext_valid ? ext_data : wb_data;

	assign reg_rdata = rf[reg_raddr];                         // entry 0 is never written

	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			for (int i = 0; i < 2**REG_AW; i++) begin
				rf[i] <= '0;
			end
		end else if (wr_en && (wr_rd != '0)) begin
			rf[wr_rd] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			commit_valid <= 1'b0;
			exc_valid    <= 1'b0;
		end else begin
			commit_valid <= wr_en;                              // writes to x0 still commit
			exc_valid    <= buf_exc;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			commit_rd   <= wr_rd;
			commit_data <= wr_data;
		end
		if (buf_exc) begin
			exc_code <= wb_exc;
		end
	end

endmodule

`default_nettype wire

//--- design/wb_buffer.sv
`default_nettype none

module wb_buffer import exe_pkg::*; (
	input  logic                clk,
	input  logic                reset_,
	input  logic                flush,

	input  logic                res_valid,
	input  logic [REG_AW-1:0]   res_rd,
	input  logic [DATA_W-1:0]   res_data,
	input  exc_code_e           res_exc,
	output logic                credit_return,

	output logic                wb_valid,
	output logic [REG_AW-1:0]   wb_rd,
	output logic [DATA_W-1:0]   wb_data,
	output exc_code_e           wb_exc,
	input  logic                wb_ack
);

	logic [REG_AW-1:0]    mem_rd   [WB_CREDITS];
	logic [DATA_W-1:0]    mem_data [WB_CREDITS];
	exc_code_e            mem_exc  [WB_CREDITS];

	logic [BUF_AW-1:0]    wr_ptr;
	logic [BUF_AW-1:0]    rd_ptr;
	logic [CREDIT_W-1:0]  count;
	logic [CREDIT_W-1:0]  count_next;
	logic                 push;
	logic                 pop;

	function automatic logic [BUF_AW-1:0] ptr_inc(input logic [BUF_AW-1:0] ptr);
		if (ptr == BUF_AW'(WB_CREDITS - 1)) begin
			return '0;
		end
		return ptr + BUF_AW'(1);
	endfunction

	assign push = res_valid && !flush;
	assign pop  = wb_valid && wb_ack;                        // head retires on this edge

	always_comb begin
		case ({push, pop})
			2'b10:   count_next = count + CREDIT_W'(1);
			2'b01:   count_next = count - CREDIT_W'(1);
			default: count_next = count;
		endcase
	end

	// head entry goes straight to the writeback stage
	assign wb_rd   = mem_rd[rd_ptr];
	assign wb_data = mem_data[rd_ptr];
	assign wb_exc  = mem_exc[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem_rd[wr_ptr]   <= res_rd;
			mem_data[wr_ptr] <= res_data;
			mem_exc[wr_ptr]  <= res_exc;
		end
	end

	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			wb_valid      <= 1'b0;
			credit_return <= 1'b0;
		end else if (flush) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			wb_valid      <= 1'b0;
			credit_return <= 1'b0;                              // the ALU restores its credits itself
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count         <= count_next;
			wb_valid      <= (count_next != '0);                // valid one cycle after arrival
			credit_return <= pop;                               // pulse in the cycle after retirement
		end
	end

	// the credit scheme upstream must keep a full buffer from ever seeing a result
	assert property (@(posedge clk) disable iff (!reset_)
		push |-> (count != CREDIT_W'(WB_CREDITS)))
	else $error("result pushed into a full buffer");

	assert property (@(posedge clk) disable iff (!reset_)
		wb_ack |-> wb_valid)
	else $error("wb_ack without wb_valid");

endmodule

`default_nettype wire

//--- design/alu_unit.sv
`default_nettype none

module alu_unit import exe_pkg::*; (
	input  logic                clk,
	input  logic                reset_,
	input  logic                flush,

	input  logic                issue_valid,
	input  alu_op_e             issue_op,
	input  logic [DATA_W-1:0]   issue_a,
	input  logic [DATA_W-1:0]   issue_b,
	input  logic [REG_AW-1:0]   issue_rd,
	output logic                issue_ready,

	input  logic                credit_return,
	output logic                res_valid,
	output logic [REG_AW-1:0]   res_rd,
	output logic [DATA_W-1:0]   res_data,
	output exc_code_e           res_exc
);

	logic [CREDIT_W-1:0]  credit_cnt;
	logic                 accept;
	logic [SHAMT_W-1:0]   shamt;
	logic [DATA_W-1:0]    alu_data;
	exc_code_e            alu_exc;

	assign issue_ready = (credit_cnt != '0);                 // a free buffer slot is guaranteed
	assign accept      = issue_valid && issue_ready && !flush;
	assign shamt       = issue_b[SHAMT_W-1:0];

	always_comb begin
		alu_data = '0;
		alu_exc  = EXC_NONE;
		case (issue_op)
			OP_ADD:  alu_data = issue_a + issue_b;              // wraps on overflow
			OP_SUB:  alu_data = issue_a - issue_b;
			OP_AND:  alu_data = issue_a & issue_b;
			OP_OR:   alu_data = issue_a | issue_b;
			OP_XOR:  alu_data = issue_a ^ issue_b;
			OP_SLL:  alu_data = issue_a << shamt;
			OP_SRL:  alu_data = issue_a >> shamt;
			OP_SRA:  alu_data = $signed(issue_a) >>> shamt;   // sign bit fills from the left
			OP_SLT: begin
				alu_data = {{(DATA_W-1){1'b0}}, ($signed(issue_a) < $signed(issue_b))};
			end
			OP_SLTU: begin
				alu_data = {{(DATA_W-1){1'b0}}, (issue_a < issue_b)};
			end
			default: begin
				alu_exc  = EXC_ILLEGAL_OP;                     // data stays zero for a bad opcode
				alu_data = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			res_valid <= 1'b0;
		end else if (flush) begin
			res_valid <= 1'b0;                                  // the result in flight is dropped
		end else begin
			res_valid <= accept;                                // one cycle per accepted issue
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			res_rd   <= issue_rd;
			res_data <= alu_data;
			res_exc  <= alu_exc;
		end
	end

	// the counter takes a credit per issue and gets one back per retired entry
	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			credit_cnt <= CREDIT_W'(WB_CREDITS);
		end else if (flush) begin
			credit_cnt <= CREDIT_W'(WB_CREDITS);               // the buffer is empty again
		end else begin
			case ({accept, credit_return})
				2'b10:   credit_cnt <= credit_cnt - CREDIT_W'(1);
				2'b01:   credit_cnt <= credit_cnt + CREDIT_W'(1);
				default: credit_cnt <= credit_cnt;              // both or neither cancel out
			endcase
		end
	end

	// a credit returned while all credits are held means the buffer lost track of an entry
	assert property (@(posedge clk) disable iff (!reset_)
		credit_cnt <= CREDIT_W'(WB_CREDITS))
	else $error("credit counter above WB_CREDITS");

	// a credit can only come back for a result that still holds one
	assert property (@(posedge clk) disable iff (!reset_)
		credit_return |-> (credit_cnt != CREDIT_W'(WB_CREDITS)))
	else $error("credit returned with no result outstanding");

endmodule

`default_nettype wire

//--- design/exe_pkg.sv
`default_nettype none

package exe_pkg;

	localparam int DATA_W     = 32;                 // operand and result width
	localparam int REG_AW     = 5;                  // 32 architectural registers
	localparam int SHAMT_W    = 5;                  // shifts only look at the low bits of b
	localparam int WB_CREDITS = 2;                  // one credit per result buffer slot
	localparam int CREDIT_W   = 2;                  // must hold 0 through WB_CREDITS
	localparam int BUF_AW     = 1;                  // pointer width for the result buffer

	// integer opcodes understood by the ALU, the codes 10 to 15 are illegal
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_SLL  = 4'd5,
		OP_SRL  = 4'd6,
		OP_SRA  = 4'd7,
		OP_SLT  = 4'd8,
		OP_SLTU = 4'd9
	} alu_op_e;

	typedef enum logic [1:0] {
		EXC_NONE       = 2'd0,
		EXC_ILLEGAL_OP = 2'd1
	} exc_code_e;

endpackage

`default_nettype wire
